// File: cache_sys.f
hw/cache_pkg.sv
hw/cache_arrays.sv
hw/cache_fill_ctrl.sv
hw/backing_mem.sv
hw/cache_sys.sv
test/clk_gen.sv
test/cache_sys_tb.sv

// File: hw/backing_mem.sv
/*
  Simulation model of the word memory. Reads return after MEM_LATENCY
  cycles, in order, with any number in flight. No back-pressure.
  Unwritten word n reads as n ^ MEM_INIT_KEY.
*/
`timescale 1ns/10ps

module backing_mem
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_req_valid,  // One request per cycle at most
  input  mem_req_t    mem_req,
  output logic        mem_rd_valid,
  output logic [15:0] mem_rd_data
);

  logic [15:0] mem [MEM_WORDS];

  //////////////////////////////////////////////////
  // Read pipeline
  //////////////////////////////////////////////////
  logic [15:0] pipe_data  [MEM_LATENCY];
  logic        pipe_valid [MEM_LATENCY];
  logic        rd_issue;

  assign rd_issue = mem_req_valid && !mem_req.write;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 16'(i) ^ MEM_INIT_KEY;
    end
  end

  // Write port and read data capture
  always_ff @(posedge clk) begin
    if (mem_req_valid && mem_req.write) begin
      mem[mem_req.addr] <= mem_req.data;
    end
    pipe_data[0] <= mem[mem_req.addr];  // Payload, validity tracked below
    for (int s = 1; s < MEM_LATENCY; s++) begin
      pipe_data[s] <= pipe_data[s-1];
    end
  end

  // Valid bits are the only state cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < MEM_LATENCY; s++) begin
        pipe_valid[s] <= 1'b0;
      end
    end else begin
      pipe_valid[0] <= rd_issue;
      for (int s = 1; s < MEM_LATENCY; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  assign mem_rd_valid = pipe_valid[MEM_LATENCY-1];
  assign mem_rd_data  = pipe_data[MEM_LATENCY-1];

endmodule

// File: hw/cache_arrays.sv
/*
  Tag, valid, LRU and data storage for 64 sets of two ways.
  Lookup is combinational on addr. Writes act at the clock edge.
  Only valid and LRU bits are cleared by reset.
*/
`timescale 1ns/10ps

module cache_arrays
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  cache_addr_u addr,        // Lookup and write address
  input  logic        write_word,  // Write wr_data into way at addr word
  input  logic        write_tag,   // Write tag_in into way at addr set
  input  logic        touch,       // Mark way as most recently used
  input  logic        way,         // Way for any write or touch
  input  logic [15:0] wr_data,
  input  tag_entry_t  tag_in,
  output logic [15:0] rd_data,     // Matching word, 0 on a miss
  output logic        hit,
  output logic        hit_way,
  output logic        lru_way      // Way to evict in this set
);

  localparam int DATA_DEPTH = NUM_SETS * LINE_WORDS;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  tag_entry_t  tags     [2][NUM_SETS];
  logic [15:0] data_ram [2][DATA_DEPTH];
  logic        lru      [NUM_SETS];   // Points at the least recently used way

  logic [SET_W+OFS_W-1:0] word_sel;   // Flat data index {set, word}
  tag_entry_t             ent0;
  tag_entry_t             ent1;
  logic                   match0;
  logic                   match1;

  assign word_sel = {addr.f.idx, addr.f.word};

  //////////////////////////////////////////////////
  // Tag and LRU writes
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        tags[0][s].valid <= 1'b0;  // Tag bits keep stale values
        tags[1][s].valid <= 1'b0;
        lru[s]           <= 1'b0;  // Way 0 evicted first
      end
    end else begin
      if (write_tag) begin
        tags[way][addr.f.idx] <= tag_in;
      end
      if (touch) begin
        lru[addr.f.idx] <= ~way;   // Point away from the used way
      end
    end
  end

  // Data words
  always_ff @(posedge clk) begin
    if (write_word) begin
      data_ram[way][word_sel] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Parallel two-way compare
  //////////////////////////////////////////////////
  assign ent0 = tags[0][addr.f.idx];
  assign ent1 = tags[1][addr.f.idx];

  assign match0 = ent0.valid && (ent0.tag == addr.f.tag);
  assign match1 = ent1.valid && (ent1.tag == addr.f.tag);

  assign hit     = match0 | match1;
  assign hit_way = match1;          // Both ways never hold the same tag
  assign lru_way = lru[addr.f.idx];

  // Word out of the matching way
  always_comb begin
    rd_data = 16'h0000;
    if (match1) begin
      rd_data = data_ram[1][word_sel];
    end else if (match0) begin
      rd_data = data_ram[0][word_sel];
    end
  end

endmodule

// File: hw/cache_fill_ctrl.sv
/*
  Request FSM. One CPU request at a time, legal only while ready is high.
  A miss refills the LRU way with eight pipelined reads and then replays
  the request as a hit. Writes go through to memory. No dirty state.
*/
`timescale 1ns/10ps

module cache_fill_ctrl
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // CPU side
  input  logic        req_valid,     // One-cycle request strobe
  input  cpu_req_t    req,
  output logic        ready,
  output logic        rsp_valid,     // One-cycle response strobe
  output cpu_rsp_t    rsp,
  // Arrays
  input  logic        hit,
  input  logic        hit_way,
  input  logic        lru_way,
  input  logic [15:0] rd_data,
  output cache_addr_u arr_addr,
  output logic        write_word,
  output logic        write_tag,
  output logic        touch,
  output logic        way,
  output logic [15:0] wr_data,
  output tag_entry_t  tag_in,
  // Backing memory
  input  logic        mem_rd_valid,
  input  logic [15:0] mem_rd_data,
  output logic        mem_req_valid,
  output mem_req_t    mem_req
);

  typedef enum logic [1:0] {
    IDLE,       // Waiting for a request
    ISSUE,      // Streaming refill reads
    WAIT_FILL,  // Draining the remaining returns
    FINISH      // Lookup and serve
  } state_t;

  localparam logic [OFS_W-1:0] LAST_WORD = OFS_W'(LINE_WORDS - 1);

  state_t           state;
  cpu_req_t         req_q;      // Latched request
  logic             victim;     // Way being refilled
  logic             missed;     // Request needed a refill
  logic [OFS_W-1:0] issue_cnt;  // Refill reads sent
  logic [OFS_W-1:0] ret_cnt;    // Refill words received

  //////////////////////////////////////////////////
  // State and control registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      rsp_valid <= 1'b0;
      missed    <= 1'b0;
      victim    <= 1'b0;
      issue_cnt <= '0;
      ret_cnt   <= '0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (req_valid) begin
            state  <= FINISH;
            missed <= 1'b0;
          end
        end
        FINISH: begin
          if (hit) begin
            state     <= IDLE;
            rsp_valid <= 1'b1;         // Ready rises with it
          end else begin
            state     <= ISSUE;        // Miss, start refill
            missed    <= 1'b1;
            victim    <= lru_way;
            issue_cnt <= '0;
            ret_cnt   <= '0;
          end
        end
        ISSUE: begin
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == LAST_WORD) state <= WAIT_FILL;
        end
        WAIT_FILL: begin
          if (mem_rd_valid && ret_cnt == LAST_WORD) state <= FINISH;  // Line complete
        end
        default: state <= IDLE;
      endcase
      if (mem_rd_valid) ret_cnt <= ret_cnt + 1'b1;  // Returns overlap ISSUE
    end
  end

  // Request and response payload
  always_ff @(posedge clk) begin
    if (ready && req_valid) req_q <= req;
    if (state == FINISH && hit) begin
      rsp.rdata <= req_q.write ? req_q.wdata : rd_data;  // Writes echo their data
      rsp.hit   <= ~missed;
    end
  end

  //////////////////////////////////////////////////
  // Array and memory commands
  //////////////////////////////////////////////////
  assign ready = (state == IDLE);

  always_comb begin
    arr_addr      = req_q.addr;
    way           = hit_way;
    wr_data       = req_q.wdata;
    tag_in.tag    = req_q.addr.f.tag;
    tag_in.valid  = 1'b1;
    write_word    = 1'b0;
    write_tag     = 1'b0;
    touch         = 1'b0;
    mem_req_valid = 1'b0;
    mem_req.addr  = {req_q.addr.f.tag, req_q.addr.f.idx, issue_cnt};  // Refill read
    mem_req.write = 1'b0;
    mem_req.data  = req_q.wdata;
    case (state)
      FINISH: begin
        if (hit) begin
          touch = 1'b1;
          if (req_q.write) begin
            write_word    = 1'b1;
            mem_req_valid = 1'b1;  // Write-through
            mem_req.write = 1'b1;
            mem_req.addr  = {req_q.addr.f.tag, req_q.addr.f.idx, req_q.addr.f.word};
          end
        end
      end
      ISSUE, WAIT_FILL: begin
        arr_addr.f.word = ret_cnt;        // Word being returned
        way             = victim;
        wr_data         = mem_rd_data;
        write_word      = mem_rd_valid;
        write_tag       = mem_rd_valid && (ret_cnt == LAST_WORD) && (state == WAIT_FILL);
        mem_req_valid   = (state == ISSUE);
      end
      default: ;
    endcase
  end

endmodule

// File: hw/cache_pkg.sv
/*
  Shared geometry and bus types for the 2 KB two-way cache.
  Addresses are 16-bit byte addresses and bit 0 is ignored (word access only).
*/
package cache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////
  localparam int TAG_W       = 6;      // Address bits 15..10
  localparam int SET_W       = 6;      // Address bits 9..4
  localparam int OFS_W       = 3;      // Word within line, bits 3..1
  localparam int NUM_SETS    = 64;
  localparam int LINE_WORDS  = 8;
  localparam int MEM_LATENCY = 3;      // Backing memory read latency in cycles
  localparam int MEM_WORDS   = 32768;  // 64 KB of 16-bit words

  // Unwritten memory word n holds n ^ key
  localparam logic [15:0] MEM_INIT_KEY = 16'hA5A5;

  // Byte address seen as its cache fields
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [SET_W-1:0] idx;
    logic [OFS_W-1:0] word;
    logic             lsb;   // Byte select, unused
  } cache_addr_f_t;

  // Same 16 bits read either raw or by field
  typedef union packed {
    logic [15:0]   raw;
    cache_addr_f_t f;
  } cache_addr_u;

  typedef struct packed {
    cache_addr_u addr;
    logic        write;
    logic [15:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [15:0] rdata;
    logic        hit;    // Served without a refill
  } cpu_rsp_t;

  typedef struct packed {
    logic [TAG_W+SET_W+OFS_W-1:0] addr;  // Word address
    logic                         write;
    logic [15:0]                  data;
  } mem_req_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             valid;
  } tag_entry_t;

endpackage

// File: hw/cache_sys.sv
/*
  Cache subsystem top. Issue a request only while ready is high.
  Responses are single-cycle strobes without back-pressure.
*/
`timescale 1ns/10ps

module cache_sys
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  cpu_req_t req,
  output logic     ready,
  output logic     rsp_valid,
  output cpu_rsp_t rsp
);

  //////////////////////////////////////////////////
  // Controller to arrays
  //////////////////////////////////////////////////
  cache_addr_u arr_addr;
  logic        write_word;
  logic        write_tag;
  logic        touch;
  logic        way;
  logic [15:0] wr_data;
  tag_entry_t  tag_in;
  logic [15:0] rd_data;
  logic        hit;
  logic        hit_way;
  logic        lru_way;

  // Controller to memory
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_rd_valid;
  logic [15:0] mem_rd_data;

  cache_fill_ctrl u_ctrl (
    .clk, .rst,
    .req_valid, .req, .ready, .rsp_valid, .rsp,
    .hit, .hit_way, .lru_way, .rd_data,
    .arr_addr, .write_word, .write_tag, .touch, .way, .wr_data, .tag_in,
    .mem_rd_valid, .mem_rd_data, .mem_req_valid, .mem_req
  );

  cache_arrays u_arrays (
    .clk, .rst,
    .addr (arr_addr),
    .write_word, .write_tag, .touch, .way, .wr_data, .tag_in,
    .rd_data, .hit, .hit_way, .lru_way
  );

  backing_mem u_mem (
    .clk, .rst,
    .mem_req_valid, .mem_req, .mem_rd_valid, .mem_rd_data
  );

endmodule

// File: test/cache_sys_tb.sv
/*
  Table-driven testbench for cache_sys. Expected data comes from a shadow
  memory, expected hit flags from a two-way LRU tag model. One request at a time.
*/
`timescale 1ns/10ps

module cache_sys_tb
  import cache_pkg::*;
();

  localparam int RST_CYCLES = 5;
  localparam int ROW_CYCLES = LINE_WORDS + MEM_LATENCY + 4;  // Worst case per request
  localparam int RAND_ROWS  = 200;

  typedef struct packed {
    logic [3:0]  test_id;
    logic        write;
    cache_addr_u addr;
    logic [15:0] wdata;
    logic [15:0] exp_data;
    logic        exp_hit;
  } row_t;

  logic     clk;
  logic     rst;
  logic     req_valid;
  cpu_req_t req;
  logic     ready;
  logic     rsp_valid;
  cpu_rsp_t rsp;

  row_t             rows [$];
  logic [15:0]      shadow [int];           // Written words by word address
  logic [TAG_W-1:0] m_tag   [2][NUM_SETS];
  logic             m_valid [2][NUM_SETS];
  logic             m_lru   [NUM_SETS];     // Way to evict next
  int               errors      = 0;
  int               test_errs   = 0;
  int               checks      = 0;
  int               cycles      = 0;
  int               cycle_limit = 0;

  clk_gen u_clk (.clk, .rst);

  cache_sys DUT (.clk, .rst, .req_valid, .req, .ready, .rsp_valid, .rsp);

  //////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////
  function automatic logic [15:0] mem_word(int wa);
    if (shadow.exists(wa)) return shadow[wa];
    return 16'(wa) ^ MEM_INIT_KEY;  // Untouched word n reads n ^ key
  endfunction

  // Runs one access through both models and appends it to the table
  function automatic void add_row(int id, logic wr, logic [15:0] addr, logic [15:0] wdata);
    row_t        r;
    cache_addr_u a;
    logic        w;
    logic        found;
    int          wa;
    a.raw = addr;
    wa    = int'(addr[15:1]);              // Bit 0 dropped
    found = 1'b0;
    w     = m_lru[a.f.idx];                // Victim unless a way matches
    for (int i = 0; i < 2; i++) begin
      if (m_valid[i][a.f.idx] && m_tag[i][a.f.idx] == a.f.tag) begin
        found = 1'b1;
        w     = 1'(i);
      end
    end
    if (!found) begin
      m_tag[w][a.f.idx]   = a.f.tag;       // Allocate on read and write miss
      m_valid[w][a.f.idx] = 1'b1;
    end
    m_lru[a.f.idx] = ~w;
    if (wr) shadow[wa] = wdata;            // Write-through keeps memory current
    r.test_id  = 4'(id);
    r.write    = wr;
    r.addr     = a;
    r.wdata    = wdata;
    r.exp_data = mem_word(wa);             // Writes echo their own data
    r.exp_hit  = found;
    rows.push_back(r);
  endfunction

  function automatic string test_name(int id);
    case (id)
      0:       return "first read misses";
      1:       return "same line hits";
      2:       return "write hit and write allocate";
      3:       return "lru eviction";
      4:       return "write-through after eviction";
      default: return "random mix";
    endcase
  endfunction

  function automatic void log_mismatch(string sig, logic [15:0] exp, logic [15:0] got);
    errors++;
    test_errs++;
    $display("error %t %s expected %h got %h", $time, sig, exp, got);
  endfunction

  //////////////////////////////////////////////////
  // Driving and checking one row
  //////////////////////////////////////////////////
  task automatic run_row(input row_t r);
    int waits;
    while (!ready) begin     // Called 5 ns after an edge
      @(posedge clk);
      #5;
    end
    req.addr  = r.addr;
    req.write = r.write;
    req.wdata = r.wdata;
    req_valid = 1'b1;
    @(posedge clk);          // Accepted here
    #5;
    req_valid = 1'b0;
    checks++;
    assert (!ready) else log_mismatch("ready", 16'd0, 16'(ready));
    waits = 0;
    do begin
      @(posedge clk);
      #5;
      waits++;
    end while (!rsp_valid);
    checks += 4;
    // Ready comes back with the response strobe
    assert (ready) else log_mismatch("ready", 16'd1, 16'(ready));
    assert (rsp.rdata == r.exp_data) else log_mismatch("rsp.rdata", r.exp_data, rsp.rdata);
    assert (rsp.hit == r.exp_hit) else log_mismatch("rsp.hit", 16'(r.exp_hit), 16'(rsp.hit));
    // A hit answers on the edge after acceptance
    assert (!r.exp_hit || waits == 1) else log_mismatch("rsp_valid latency", 16'd1, 16'(waits));
  endtask

  //////////////////////////////////////////////////
  // Table and main sequence
  //////////////////////////////////////////////////
  initial begin
    cache_addr_u ra;
    logic        wr;
    logic [15:0] wd;
    int          n_rows;
    req_valid = 1'b0;
    req       = '0;
    $timeformat(-9, 1, " ns", 10);
    void'($urandom(5));                    // Single seed for the whole run
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_lru[s]      = 1'b0;
    end

    add_row(0, 1'b0, 16'h0000, 16'h0000);  // Set 0 and tag 0
    add_row(0, 1'b0, 16'h1234, 16'h0000);  // Set 0x23 and tag 4
    add_row(1, 1'b0, 16'h0004, 16'h0000);  // Same line as 0x0000
    add_row(1, 1'b0, 16'h123E, 16'h0000);
    add_row(2, 1'b1, 16'h0008, 16'hBEEF);  // Write hit
    add_row(2, 1'b0, 16'h0008, 16'h0000);
    add_row(2, 1'b1, 16'h4010, 16'h1357);  // Write miss allocates
    add_row(2, 1'b0, 16'h4010, 16'h0000);
    add_row(3, 1'b0, 16'h0020, 16'h0000);  // A
    add_row(3, 1'b0, 16'h0420, 16'h0000);  // B
    add_row(3, 1'b0, 16'h0020, 16'h0000);  // A again
    add_row(3, 1'b0, 16'h0820, 16'h0000);  // C evicts B
    add_row(3, 1'b0, 16'h0020, 16'h0000);  // A still present
    add_row(3, 1'b0, 16'h0420, 16'h0000);  // B gone
    add_row(4, 1'b1, 16'h0030, 16'hCAFE);
    add_row(4, 1'b0, 16'h0430, 16'h0000);
    add_row(4, 1'b0, 16'h0830, 16'h0000);  // Pushes out the written line
    add_row(4, 1'b0, 16'h0030, 16'h0000);  // Refetched from memory

    // Four tags over four sets with the ignored bit 0 left random
    for (int i = 0; i < RAND_ROWS; i++) begin
      ra.f.tag  = TAG_W'($urandom_range(0, 3));
      ra.f.idx  = SET_W'(8 + $urandom_range(0, 3));
      ra.f.word = OFS_W'($urandom);
      ra.f.lsb  = 1'($urandom);
      wr        = 1'($urandom);
      wd        = 16'($urandom);
      add_row(5, wr, ra.raw, wd);
    end
    cycle_limit = rows.size() * ROW_CYCLES + RST_CYCLES + 2;

    @(negedge rst);
    n_rows = 0;
    foreach (rows[i]) begin
      run_row(rows[i]);
      n_rows++;
      if (i == rows.size() - 1 || rows[i+1].test_id != rows[i].test_id) begin
        $display("test %0d %s: %0d rows, %0d errors", rows[i].test_id,
                 test_name(rows[i].test_id), n_rows, test_errs);
        n_rows    = 0;
        test_errs = 0;
      end
    end

    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Cycle budget for the whole table
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the DUT did not finish the table within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

// File: test/clk_gen.sv
/*
  Testbench clock and reset. 100 ns period, rst high for the first 5 edges.
*/
`timescale 1ns/10ps

module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // Release lands 5 ns after an edge, like all other stimulus
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #5 rst = 1'b0;
  end

endmodule
